// ==== Bender.yml ====
package:
  name: pin_array

sources:
  - include_dirs:
      - common
    files:
      - common/pin_regs_pkg.sv
      - common/pin_types_pkg.sv
      - pin_channel/pin_channel.sv
      - rtl/cmd_bus_port.sv
      - rtl/sample_arbiter.sv
      - rtl/pin_array.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/pin_array_tb.sv

// ==== common/pin_defines.svh ====
`ifndef PIN_DEFINES_SVH
`define PIN_DEFINES_SVH

// Number of pin channels in the array.
`define PIN_NUM_CHANNELS 4

// Command bus address fields, channel in the upper byte.
`define PIN_CHAN_W 8
`define PIN_REG_W 8

// Command bus data widths.
`define PIN_DATA_W 32
`define PIN_RDATA_W 16

// Time base and NCO.
`define PIN_TIME_W 32
`define PIN_PHASE_W 32

// Sample word and its count field.
`define PIN_SAMPLE_W 32
`define PIN_COUNT_W 16

`endif

// ==== common/pin_regs_pkg.sv ====
`include "pin_defines.svh"

package pin_regs_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Register offsets inside one channel window.
  typedef enum logic [`PIN_REG_W-1:0] {
    reg_nco_step     = 1,  // NCO phase step.
    reg_end_time     = 2,  // Mode ends at this time.
    reg_command      = 3,  // Pending command, cleared when taken.
    reg_sample_rate  = 4,  // Cycles between samples.
    reg_sample_level = 5,  // Last sampled pin level.
    reg_sample_count = 7,  // Running sample count.
    reg_status       = 8,  // Channel index.
    reg_last_data    = 9   // Low half of the last write.
  } reg_addr_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // Command codes written to reg_command.
  typedef enum logic [`PIN_DATA_W-1:0] {
    cmd_const_high   = 2,
    cmd_square_wave  = 3,
    cmd_input_stream = 4,
    cmd_stop         = 5
  } cmd_e;

endpackage

// ==== common/pin_types_pkg.sv ====
`include "pin_defines.svh"

package pin_types_pkg;

  typedef logic [`PIN_CHAN_W+`PIN_REG_W-1:0] bus_addr_t;  // Channel byte, then register byte.
  typedef logic [`PIN_DATA_W-1:0]            wdata_t;
  typedef logic [`PIN_RDATA_W-1:0]           rdata_t;
  typedef logic [`PIN_CHAN_W-1:0]            chan_idx_t;
  typedef logic [`PIN_TIME_W-1:0]            time_t;
  typedef logic [`PIN_PHASE_W-1:0]           phase_t;
  typedef logic [`PIN_COUNT_W-1:0]           count_t;
  typedef logic [`PIN_SAMPLE_W-1:0]          sample_word_t;

  // Zero bits between the channel index and the level bit.
  localparam int sample_pad_w = `PIN_SAMPLE_W - `PIN_COUNT_W - `PIN_CHAN_W - 1;

  // Channel modes.
  typedef enum logic [1:0] {
    state_idle,
    state_const_high,
    state_square_wave,
    state_input_stream
  } chan_state_t;

  // Sample word is count, channel index, zero pad, pin level.
  function automatic sample_word_t make_sample(count_t count, chan_idx_t index, logic level);
    return {count, index, {sample_pad_w{1'b0}}, level};
  endfunction

endpackage

// ==== dv/pin_array_tb.sv ====
`timescale 1ns/1ns
`include "pin_defines.svh"

module pin_array_tb;
  import pin_types_pkg::*;
  import pin_regs_pkg::*;

  localparam int n_ch = `PIN_NUM_CHANNELS;

  logic            clk;
  logic            reset;
  logic            enable;
  bus_addr_t       addr;
  wdata_t          data_in;
  logic            data_wr;
  logic            data_rd;
  rdata_t          data_out;
  time_t           current_time;
  logic [n_ch-1:0] pin_out;
  logic [n_ch-1:0] pin_oe;
  logic [n_ch-1:0] pin_in;
  logic            sample_valid;
  sample_word_t    sample_data;

  integer          seed;
  wdata_t          rnd;
  time_t           time_cnt;
  rdata_t          exp_rdata;   // Expected data_out for the read in flight.
  logic            const_chk;
  logic            sq_chk;
  logic            arb_chk;
  int              const_ch;
  int              sq_ch;
  int              stream_ch;   // Only streaming channel, or -1.
  time_t           const_end;
  int              over_age;    // Cycles since current_time passed const_end.
  int              run_len;
  logic            run_level;
  logic [n_ch-1:0] stop_mask;   // Set once a stopped channel may hold one last sample.
  count_t          last_cnt [n_ch];
  int              seen_cnt [n_ch];
  int              late_cnt [n_ch];
  int              gap_cnt [n_ch];
  int              stop_age [n_ch];
  chan_idx_t       smp_ch;

  pin_array pin_array_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Free-running time base that restarts at 1 in reset.
  always @(negedge clk) begin
    time_cnt     = reset ? 32'd1 : time_cnt + 1;
    current_time = time_cnt;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Trackers for the checks.
  assign smp_ch = sample_data[15:8];

  always @(posedge clk) begin
    over_age <= (const_chk && current_time >= const_end) ? over_age + 1 : 0;
    if (pin_out[sq_ch] == run_level) begin
      run_len <= run_len + 1;
    end else begin
      run_len   <= 1;
      run_level <= pin_out[sq_ch];
    end
    for (int i = 0; i < n_ch; i++) begin
      if (enable && data_wr && addr == {chan_idx_t'(i), reg_command}) begin
        stop_age[i] <= (data_in == cmd_stop) ? 1 : 0;
      end else if (stop_age[i] != 0 && stop_age[i] < 3) begin
        stop_age[i] <= stop_age[i] + 1;  // Saturates at 3.
      end
      if (sample_valid && smp_ch == chan_idx_t'(i)) begin
        last_cnt[i] <= sample_data[31:16];
        seen_cnt[i] <= seen_cnt[i] + 1;
        late_cnt[i] <= stop_mask[i] ? late_cnt[i] + 1 : 0;
        gap_cnt[i]  <= 0;
      end else begin
        late_cnt[i] <= stop_mask[i] ? late_cnt[i] : 0;
        gap_cnt[i]  <= arb_chk ? gap_cnt[i] + 1 : 0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Assertions.
  a_read: assert property (@(posedge clk) disable iff (reset)
    (enable && data_rd) |=> (data_out == $past(exp_rdata)))
    else report_error("read data differs from expected value");
  a_read_idle: assert property (@(posedge clk) disable iff (reset)
    !(enable && data_rd) |=> (data_out == '0))
    else report_error("data_out not zero after a cycle without read");
  a_const_level: assert property (@(posedge clk) disable iff (reset)
    (const_chk && pin_oe[const_ch]) |-> pin_out[const_ch])
    else report_error("pin_out low during constant drive");
  a_const_end: assert property (@(posedge clk) disable iff (reset)
    (const_chk && over_age >= 2) |-> !pin_oe[const_ch])
    else report_error("pin_oe still high two cycles after end_time");
  a_sq_oe: assert property (@(posedge clk) disable iff (reset)
    sq_chk |-> pin_oe[sq_ch])
    else report_error("square wave stopped with end_time zero");
  a_sq_run: assert property (@(posedge clk) disable iff (reset)
    (sq_chk && pin_out[sq_ch] != run_level) |-> (run_len == 4))
    else report_error("square wave run is not 4 cycles");
  a_sample: assert property (@(posedge clk) disable iff (reset)
    sample_valid |-> (smp_ch < n_ch && sample_data[7:1] == '0
      && sample_data[0] == pin_in[smp_ch]
      && sample_data[31:16] == count_t'(last_cnt[smp_ch] + 1)))
    else report_error("sample word has wrong index, level or count");
  a_stream_index: assert property (@(posedge clk) disable iff (reset)
    (sample_valid && stream_ch >= 0) |-> (smp_ch == chan_idx_t'(stream_ch)))
    else report_error("sample word carries the wrong channel index");

  for (genvar i = 0; i < n_ch; i++) begin : g_chk
    a_stop: assert property (@(posedge clk) disable iff (reset)
      (stop_age[i] == 3) |-> !pin_oe[i])
      else report_error("pin_oe still high two cycles after stop");
    a_gap: assert property (@(posedge clk) disable iff (reset)
      arb_chk |-> (gap_cnt[i] <= 2 * n_ch))
      else report_error("channel starved on the sample port");
    a_late: assert property (@(posedge clk) disable iff (reset)
      late_cnt[i] <= 1)
      else report_error("more than one sample after stop");
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Tasks are all entered at a falling edge.
  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "Check failed.");
  endtask

  task automatic report_timeout(input string msg);
    $display("Timed out waiting for %s at %0t ns.", msg, $time);
    $display("Result: FAILED");
    $fatal(1, "Timeout.");
  endtask

  task automatic write_reg(input int ch, input logic [7:0] offset, input wdata_t data);
    enable  = 1'b1;
    data_wr = 1'b1;
    addr    = {chan_idx_t'(ch), offset};
    data_in = data;
    @(negedge clk);
    enable  = 1'b0;
    data_wr = 1'b0;
  endtask

  task automatic read_reg(input int ch, input logic [7:0] offset, input rdata_t expected);
    enable    = 1'b1;
    data_rd   = 1'b1;
    addr      = {chan_idx_t'(ch), offset};
    exp_rdata = expected;
    @(negedge clk);
    enable  = 1'b0;
    data_rd = 1'b0;
  endtask

  task automatic wait_oe(input int ch, input logic level, input int limit);
    int n;
    n = 0;
    while (pin_oe[ch] !== level) begin
      if (n == limit) begin
        report_timeout("pin_oe");
      end else begin
        n++;
        @(negedge clk);
      end
    end
  endtask

  task automatic wait_rises(input int ch, input int count, input int limit);
    int   n;
    int   rises;
    logic prev;
    n     = 0;
    rises = 0;
    prev  = pin_out[ch];
    while (rises < count) begin
      if (n == limit) begin
        report_timeout("square wave edges");
      end else begin
        n++;
        @(negedge clk);
        if (pin_out[ch] && !prev) rises++;
        prev = pin_out[ch];
      end
    end
  endtask

  task automatic wait_samples(input int ch, input int target, input int limit);
    int n;
    n = 0;
    while (seen_cnt[ch] < target) begin
      if (n == limit) begin
        report_timeout("samples");
      end else begin
        n++;
        @(negedge clk);
      end
    end
  endtask

  // Stop, then allow one pending sample once the FSM is idle.
  task automatic stop_stream(input int ch);
    write_reg(ch, reg_command, cmd_stop);
    repeat (2) @(negedge clk);
    stop_mask[ch] = 1'b1;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus.
  initial begin
    seed = 32'h045d_9565;
    reset = 1'b1;
    enable = 1'b0;
    addr = '0;
    data_in = '0;
    data_wr = 1'b0;
    data_rd = 1'b0;
    pin_in = '0;
    time_cnt = 32'd1;
    current_time = 32'd1;
    exp_rdata = '0;
    const_chk = 1'b0;
    sq_chk = 1'b0;
    arb_chk = 1'b0;
    const_ch = 1;
    sq_ch = 2;
    stream_ch = -1;
    const_end = '0;
    over_age = 0;
    run_len = 0;
    run_level = 1'b0;
    stop_mask = '0;
    for (int i = 0; i < n_ch; i++) begin
      last_cnt[i] = '0;
      seen_cnt[i] = 0;
      late_cnt[i] = 0;
      gap_cnt[i]  = 0;
      stop_age[i] = 0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Register path.
    for (int ch = 0; ch < n_ch; ch++) begin
      rnd = $random(seed);
      write_reg(ch, reg_last_data, rnd);
      read_reg(ch, reg_last_data, rnd[15:0]);
      read_reg(ch, reg_status, rdata_t'(ch));
      read_reg(ch, 8'h00, '0);
      read_reg(ch, 8'h06, '0);
    end
    read_reg(n_ch, reg_status, '0);
    read_reg(255, reg_last_data, '0);

    // Constant drive with a natural end.
    const_end = time_cnt + 40;
    write_reg(const_ch, reg_end_time, const_end);
    write_reg(const_ch, reg_command, cmd_const_high);
    wait_oe(const_ch, 1'b1, 8);
    const_chk = 1'b1;
    wait_oe(const_ch, 1'b0, 60);
    repeat (4) @(negedge clk);
    const_chk = 1'b0;

    // Square wave where step 2^29 gives runs of 4.
    write_reg(sq_ch, reg_nco_step, 32'h2000_0000);
    write_reg(sq_ch, reg_end_time, '0);
    write_reg(sq_ch, reg_command, cmd_square_wave);
    wait_oe(sq_ch, 1'b1, 8);
    wait_rises(sq_ch, 1, 16);
    @(negedge clk);
    sq_chk = 1'b1;
    wait_rises(sq_ch, 4, 64);
    sq_chk = 1'b0;
    write_reg(sq_ch, reg_command, cmd_stop);
    wait_oe(sq_ch, 1'b0, 8);

    // Stop during constant drive.
    write_reg(n_ch - 1, reg_end_time, time_cnt + 1000);
    write_reg(n_ch - 1, reg_command, cmd_const_high);
    wait_oe(n_ch - 1, 1'b1, 8);
    write_reg(n_ch - 1, reg_command, cmd_stop);
    wait_oe(n_ch - 1, 1'b0, 8);

    // Single channel stream at rate 2.
    stream_ch = 1;
    pin_in = $random(seed);
    write_reg(stream_ch, reg_sample_rate, 2);
    write_reg(stream_ch, reg_command, cmd_input_stream);
    wait_samples(stream_ch, 8, 64);
    stop_stream(stream_ch);
    repeat (4 * n_ch) @(negedge clk);

    // All channels streaming through the arbiter.
    stream_ch = -1;
    stop_mask = '0;
    for (int ch = 0; ch < n_ch; ch++) begin
      write_reg(ch, reg_sample_rate, n_ch);
      write_reg(ch, reg_command, cmd_input_stream);
    end
    repeat (2 * n_ch) @(negedge clk);
    arb_chk = 1'b1;
    for (int ch = 0; ch < n_ch; ch++) begin
      wait_samples(ch, seen_cnt[ch] + 10, 20 * n_ch);
    end
    arb_chk = 1'b0;
    for (int ch = 0; ch < n_ch; ch++) begin
      stop_stream(ch);
    end
    repeat (4 * n_ch) @(negedge clk);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== pin_array.f ====
+incdir+common
common/pin_regs_pkg.sv
common/pin_types_pkg.sv
pin_channel/pin_channel.sv
rtl/cmd_bus_port.sv
rtl/sample_arbiter.sv
rtl/pin_array.sv
dv/pin_array_tb.sv

// ==== pin_channel/pin_channel.sv ====
`timescale 1ns/1ns
`include "pin_defines.svh"

module pin_channel (
  input  logic                        clk,
  input  logic                        reset,
  input  pin_types_pkg::chan_idx_t    index,
  input  logic                        wr,
  input  logic                        rd,
  input  logic [`PIN_REG_W-1:0]       reg_addr,
  input  pin_types_pkg::wdata_t       wdata,
  input  pin_types_pkg::time_t        current_time,
  input  logic                        pin_in,
  input  logic                        sample_grant,
  output pin_types_pkg::rdata_t       rdata,
  output logic                        pin_out,
  output logic                        pin_oe,
  output logic                        sample_req,
  output pin_types_pkg::sample_word_t sample_word
);
  import pin_types_pkg::*;
  import pin_regs_pkg::*;

  phase_t      nco_step;
  time_t       end_time;
  wdata_t      command;
  wdata_t      sample_rate;
  rdata_t      last_data;

  chan_state_t state;
  chan_state_t state_next;
  logic        cmd_valid;
  logic        cmd_stop_seen;
  logic        cmd_clear;

  phase_t      nco_acc;
  wdata_t      rate_cnt;
  logic        take_sample;
  logic        sample_level;
  count_t      sample_cnt;
  logic        pending;

  // ~~~~~~~~~~~~~~~~~~~~
  // Register writes.
  always_ff @(posedge clk) begin
    if (reset) begin
      nco_step    <= '0;
      end_time    <= '0;
      sample_rate <= '0;
    end else if (wr) begin
      case (reg_addr)
        reg_nco_step:    nco_step    <= wdata;
        reg_end_time:    end_time    <= wdata;
        reg_sample_rate: sample_rate <= wdata;
        default: ;
      endcase
    end
  end

  // A new write wins over the clear from the FSM.
  always_ff @(posedge clk) begin
    if (reset) begin
      command <= '0;
    end else if (wr && reg_addr == reg_command) begin
      command <= wdata;
    end else if (cmd_clear) begin
      command <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      last_data <= wdata[`PIN_RDATA_W-1:0];  // Any offset in this window.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Mode FSM.
  assign cmd_valid = command inside {cmd_const_high, cmd_square_wave, cmd_input_stream, cmd_stop};
  assign cmd_stop_seen = (command == cmd_stop);

  always_comb begin
    state_next = state;
    cmd_clear  = 1'b0;
    case (state)
      state_idle: begin
        // Commands wait until the time base is running.
        if (current_time != '0 && cmd_valid) begin
          cmd_clear = 1'b1;
          case (command)
            cmd_const_high:   state_next = state_const_high;
            cmd_square_wave:  state_next = state_square_wave;
            cmd_input_stream: state_next = state_input_stream;
            default:          state_next = state_idle;  // Stop only clears.
          endcase
        end
      end
      state_const_high: begin
        if (cmd_stop_seen || current_time >= end_time) begin
          state_next = state_idle;
        end
        cmd_clear = cmd_stop_seen;
      end
      state_square_wave: begin
        // End time of zero means run until stopped.
        if (cmd_stop_seen || (end_time != '0 && current_time >= end_time)) begin
          state_next = state_idle;
        end
        cmd_clear = cmd_stop_seen;
      end
      default: begin
        if (cmd_stop_seen) begin
          state_next = state_idle;
        end
        cmd_clear = cmd_stop_seen;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      state <= state_next;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // NCO and pin drive one cycle behind the state.
  always_ff @(posedge clk) begin
    if (reset) begin
      pin_oe  <= 1'b0;
      nco_acc <= '0;
    end else begin
      pin_oe <= (state == state_const_high) || (state == state_square_wave);
      case (state)
        state_const_high:  nco_acc <= '1;  // MSB held high.
        state_square_wave: nco_acc <= nco_acc + nco_step;
        default:           nco_acc <= '0;
      endcase
    end
  end

  assign pin_out = nco_acc[`PIN_PHASE_W-1];

  // ~~~~~~~~~~~~~~~~~~~~
  // Input streaming.
  assign take_sample = (state == state_input_stream) && (rate_cnt <= 1);  // Rate 0 acts as 1.

  always_ff @(posedge clk) begin
    if (reset) begin
      rate_cnt <= '0;
    end else if (state != state_input_stream) begin
      rate_cnt <= '0;
    end else if (take_sample) begin
      rate_cnt <= sample_rate;
    end else begin
      rate_cnt <= rate_cnt - 1'b1;
    end
  end

  // A newer sample replaces one that is still waiting.
  always_ff @(posedge clk) begin
    if (reset) begin
      sample_cnt <= '0;
      pending    <= 1'b0;
    end else if (take_sample) begin
      sample_cnt <= sample_cnt + 1'b1;
      pending    <= 1'b1;
    end else if (sample_grant) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_sample) begin
      sample_level <= pin_in;
    end
  end

  assign sample_req  = pending;
  assign sample_word = make_sample(sample_cnt, index, sample_level);

  // Read value is zero unless this channel is read.
  always_comb begin
    rdata = '0;
    if (rd) begin
      case (reg_addr)
        reg_sample_level: rdata = rdata_t'(sample_level);
        reg_sample_count: rdata = rdata_t'(sample_cnt);
        reg_status:       rdata = rdata_t'(index);
        reg_last_data:    rdata = last_data;
        default:          rdata = '0;
      endcase
    end
  end

endmodule

// ==== rtl/cmd_bus_port.sv ====
`timescale 1ns/1ns
`include "pin_defines.svh"

module cmd_bus_port (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable,
  input  pin_types_pkg::bus_addr_t     addr,
  input  logic                         data_wr,
  input  logic                         data_rd,
  input  pin_types_pkg::rdata_t        chan_rdata [`PIN_NUM_CHANNELS],
  output logic [`PIN_NUM_CHANNELS-1:0] chan_wr,
  output logic [`PIN_NUM_CHANNELS-1:0] chan_rd,
  output logic [`PIN_REG_W-1:0]        reg_addr,
  output pin_types_pkg::rdata_t        data_out
);
  import pin_types_pkg::*;

  chan_idx_t chan_field;
  rdata_t    rd_sel;

  assign chan_field = addr[`PIN_CHAN_W+`PIN_REG_W-1:`PIN_REG_W];
  assign reg_addr   = addr[`PIN_REG_W-1:0];

  // One-hot strobes, none for an index past the last channel.
  always_comb begin
    chan_wr = '0;
    chan_rd = '0;
    for (int i = 0; i < `PIN_NUM_CHANNELS; i++) begin
      if (enable && chan_field == chan_idx_t'(i)) begin
        chan_wr[i] = data_wr;
        chan_rd[i] = data_rd;
      end
    end
  end

  // Read mux on the one-hot read strobe.
  always_comb begin
    rd_sel = '0;
    for (int i = 0; i < `PIN_NUM_CHANNELS; i++) begin
      if (chan_rd[i]) begin
        rd_sel = chan_rdata[i];
      end
    end
  end

  // Held for one cycle, back to zero without a new read.
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else if (|chan_rd) begin
      data_out <= rd_sel;
    end else begin
      data_out <= '0;
    end
  end

endmodule

// ==== rtl/pin_array.sv ====
`timescale 1ns/1ns
`include "pin_defines.svh"

module pin_array (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable,
  input  pin_types_pkg::bus_addr_t     addr,
  input  pin_types_pkg::wdata_t        data_in,
  input  logic                         data_wr,
  input  logic                         data_rd,
  output pin_types_pkg::rdata_t        data_out,
  input  pin_types_pkg::time_t         current_time,
  output logic [`PIN_NUM_CHANNELS-1:0] pin_out,
  output logic [`PIN_NUM_CHANNELS-1:0] pin_oe,
  input  logic [`PIN_NUM_CHANNELS-1:0] pin_in,
  output logic                         sample_valid,
  output pin_types_pkg::sample_word_t  sample_data
);
  import pin_types_pkg::*;

  logic [`PIN_NUM_CHANNELS-1:0] chan_wr;
  logic [`PIN_NUM_CHANNELS-1:0] chan_rd;
  logic [`PIN_REG_W-1:0]        reg_addr;
  rdata_t                       chan_rdata [`PIN_NUM_CHANNELS];
  logic [`PIN_NUM_CHANNELS-1:0] sample_req;
  logic [`PIN_NUM_CHANNELS-1:0] sample_grant;
  sample_word_t                 sample_word [`PIN_NUM_CHANNELS];

  cmd_bus_port cmd_bus_port_inst (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .addr       (addr),
    .data_wr    (data_wr),
    .data_rd    (data_rd),
    .chan_rdata (chan_rdata),
    .chan_wr    (chan_wr),
    .chan_rd    (chan_rd),
    .reg_addr   (reg_addr),
    .data_out   (data_out)
  );

  // Channel index is fixed per instance.
  for (genvar i = 0; i < `PIN_NUM_CHANNELS; i++) begin : g_chan
    pin_channel pin_channel_inst (
      .clk          (clk),
      .reset        (reset),
      .index        (chan_idx_t'(i)),
      .wr           (chan_wr[i]),
      .rd           (chan_rd[i]),
      .reg_addr     (reg_addr),
      .wdata        (data_in),
      .current_time (current_time),
      .pin_in       (pin_in[i]),
      .sample_grant (sample_grant[i]),
      .rdata        (chan_rdata[i]),
      .pin_out      (pin_out[i]),
      .pin_oe       (pin_oe[i]),
      .sample_req   (sample_req[i]),
      .sample_word  (sample_word[i])
    );
  end

  sample_arbiter sample_arbiter_inst (
    .clk          (clk),
    .reset        (reset),
    .sample_req   (sample_req),
    .sample_word  (sample_word),
    .sample_grant (sample_grant),
    .sample_valid (sample_valid),
    .sample_data  (sample_data)
  );

endmodule

// ==== rtl/sample_arbiter.sv ====
`timescale 1ns/1ns
`include "pin_defines.svh"

module sample_arbiter (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`PIN_NUM_CHANNELS-1:0] sample_req,
  input  pin_types_pkg::sample_word_t  sample_word [`PIN_NUM_CHANNELS],
  output logic [`PIN_NUM_CHANNELS-1:0] sample_grant,
  output logic                         sample_valid,
  output pin_types_pkg::sample_word_t  sample_data
);
  import pin_types_pkg::*;

  localparam int ptr_w = (`PIN_NUM_CHANNELS > 1) ? $clog2(`PIN_NUM_CHANNELS) : 1;

  logic [ptr_w-1:0] last_ptr;  // Last winner.
  logic [ptr_w-1:0] win_ptr;

  // ~~~~~~~~~~~~~~~~~~~~
  // Search starts one past the last winner and wraps.
  always_comb begin
    int cand;
    sample_grant = '0;
    win_ptr      = last_ptr;
    for (int k = 1; k <= `PIN_NUM_CHANNELS; k++) begin
      cand = (int'(last_ptr) + k) % `PIN_NUM_CHANNELS;
      if (sample_grant == '0 && sample_req[cand]) begin
        sample_grant[cand] = 1'b1;
        win_ptr            = ptr_w'(cand);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Output register.
  always_ff @(posedge clk) begin
    if (reset) begin
      last_ptr     <= ptr_w'(`PIN_NUM_CHANNELS - 1);  // Channel 0 goes first.
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= |sample_grant;
      if (|sample_grant) begin
        last_ptr <= win_ptr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (|sample_grant) begin
      sample_data <= sample_word[win_ptr];
    end
  end

endmodule
